//--- src.f
src/core_cfg_pkg.sv
src/bridge_config_regs.sv
src/core_reset_timer.sv
src/control_panel_mapper.sv
src/core_front_top.sv
test/tb_clk_gen.sv
test/tb_core_checks.sv
test/tb_core_front.sv

//--- src/bridge_config_regs.sv
// bridge write decode and configuration registers
// reset request pulse for reset and dip writes
// read buffer and bridge read multiplexer

`timescale 1ns/100ps

module bridge_config_regs (
    input  logic                        clk_74a,
    input  logic                        temp_reset,
    input  core_cfg_pkg::bridge_req_t   bridge,
    input  logic [31:0]                 cmd_rd_data,
    input  logic                        core_reset,
    output logic [31:0]                 rd_data,
    output core_cfg_pkg::dip_word_u     dip,
    output logic [7:0]                  core_mode,
    output logic [3:0]                  scanline_level,
    output logic                        core_reset_req
);

    import core_cfg_pkg::*;

    logic [31:0] mode_word;
    logic [31:0] scnl_word;
    logic [31:0] read_buf;

    logic        wr_reset;
    logic        wr_dip;
    logic        wr_mode;
    logic        wr_scnl;
    logic        in_cmd_region;

    //////////////////////////////////////////////////
    // write decode
    //////////////////////////////////////////////////

    assign wr_reset = bridge.wr && (bridge.addr == addr_reset);
    assign wr_dip   = bridge.wr && (bridge.addr == addr_dip);
    assign wr_mode  = bridge.wr && (bridge.addr == addr_mode);
    assign wr_scnl  = bridge.wr && (bridge.addr == addr_scanlines);

    // configuration words, full 32 bits kept for readback
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            dip.raw   <= '0;
            mode_word <= '0;
            scnl_word <= '0;
        end else begin
            if (wr_dip) begin
                dip.raw <= bridge.wr_data;
            end
            if (wr_mode) begin
                mode_word <= bridge.wr_data;
            end
            if (wr_scnl) begin
                scnl_word <= bridge.wr_data;
            end
        end
    end

    // request pulse to the reset timer
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            core_reset_req <= 1'b0;
        end else begin
            core_reset_req <= wr_reset || wr_dip;
        end
    end

    assign core_mode      = mode_word[7:0];
    assign scanline_level = scnl_word[3:0];

    //////////////////////////////////////////////////
    // read side
    //////////////////////////////////////////////////

    // latched on the read strobe, held until the next read
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            read_buf <= '0;
        end else if (bridge.rd) begin
            case (bridge.addr)
                addr_reset:     read_buf <= {31'd0, core_reset};
                addr_dip:       read_buf <= dip.raw;
                addr_mode:      read_buf <= mode_word;
                addr_scanlines: read_buf <= scnl_word;
                default:        read_buf <= read_buf;
            endcase
        end
    end

    assign in_cmd_region = (bridge.addr[31:24] == cmd_region);

    // command space passes straight through, unmapped reads zero
    always_comb begin
        if (in_cmd_region) begin
            rd_data = cmd_rd_data;
        end else begin
            case (bridge.addr)
                addr_reset,
                addr_dip,
                addr_mode,
                addr_scanlines: rd_data = read_buf;
                default:        rd_data = 32'd0;
            endcase
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // request stays a single-cycle pulse
    req_single_pulse: assert property (
        @(posedge clk_74a) disable iff (temp_reset)
        core_reset_req |=> !core_reset_req
    ) else $error("core_reset_req high for two cycles");

endmodule

//--- src/control_panel_mapper.sv
// controller mapper for pads 1 and 2
// per-pad decode, player merge and registered active-low panel

`timescale 1ns/100ps

module control_panel_mapper (
    input  logic                     clk_74a,
    input  logic                     temp_reset,
    input  core_cfg_pkg::pad_key_t   cont1_key,
    input  core_cfg_pkg::pad_key_t   cont2_key,
    output core_cfg_pkg::panel_t     control_panel
);

    import core_cfg_pkg::*;

    panel_t p1_panel;
    panel_t p2_panel;
    panel_t merged;

    //////////////////////////////////////////////////
    // pad decode
    //////////////////////////////////////////////////

    // active-high panel bits for one pad
    // second selects which start button the pad owns
    function automatic panel_t map_pad(input pad_key_t key, input logic second);
        panel_t p;
        p        = '0;
        p.coin   = key.select;
        p.start1 = key.start & ~second;
        p.start2 = key.start & second;
        // b fires, y is the second button
        p.shoot  = key.face_b;
        p.shoot2 = key.face_y;
        p.up     = key.dpad_up;
        p.down   = key.dpad_down;
        p.left   = key.dpad_left;
        p.right  = key.dpad_right;
        return p;
    endfunction

    assign p1_panel = map_pad(cont1_key, 1'b0);
    assign p2_panel = map_pad(cont2_key, 1'b1);

    // either player can coin, move or fire
    // starts stay apart since each pad drives only its own
    assign merged = p1_panel | p2_panel;

    //////////////////////////////////////////////////
    // output register
    //////////////////////////////////////////////////

    // all ones means nothing pressed
    always_ff @(posedge clk_74a) begin
        if (temp_reset) begin
            control_panel <= '1;
        end else begin
            control_panel <= ~merged;
        end
    end

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // core must never see a floating control line
    panel_known: assert property (
        @(posedge clk_74a) disable iff (temp_reset)
        !$isunknown(control_panel)
    ) else $error("control_panel unknown after reset");

endmodule

//--- src/core_cfg_pkg.sv
// shared definitions for the core configuration front end
// bridge register map, command region and reset stretch default
// bridge access struct, dip word union, pad key and control panel types

package core_cfg_pkg;

    //////////////////////////////////////////////////
    // bridge register map
    //////////////////////////////////////////////////

    // one 32-bit word at each address
    localparam logic [31:0] addr_reset     = 32'hF000_0000;
    localparam logic [31:0] addr_dip       = 32'hF100_0000;
    localparam logic [31:0] addr_mode      = 32'hF200_0000;
    localparam logic [31:0] addr_scanlines = 32'hF300_0000;

    // top address byte of the host command handler space
    localparam logic [7:0] cmd_region = 8'hF8;

    // core reset stretch, in clk_74a cycles
    localparam logic [31:0] default_reset_hold = 32'd8000;

    //////////////////////////////////////////////////
    // bridge access
    //////////////////////////////////////////////////

    // one bridge access as seen in a single cycle
    typedef struct packed {
        logic        rd;
        logic        wr;
        logic [31:0] addr;
        logic [31:0] wr_data;
    } bridge_req_t;

    //////////////////////////////////////////////////
    // dip switch word
    //////////////////////////////////////////////////

    // dsw0 sits in the low byte
    typedef struct packed {
        logic [7:0] spare;
        logic [7:0] dsw2;
        logic [7:0] dsw1;
        logic [7:0] dsw0;
    } dip_fields_t;

    // raw view for readback, field view for the core
    typedef union packed {
        logic [31:0] raw;
        dip_fields_t sw;
    } dip_word_u;

    //////////////////////////////////////////////////
    // controller input and core control panel
    //////////////////////////////////////////////////

    // pad key word, bit 0 is dpad up
    typedef struct packed {
        logic [2:0]  pad_type;
        logic [12:0] unused;
        logic        start;
        logic        select;
        logic        click_r;
        logic        click_l;
        logic        trig_r2;
        logic        trig_l2;
        logic        trig_r1;
        logic        trig_l1;
        logic        face_y;
        logic        face_x;
        logic        face_b;
        logic        face_a;
        logic        dpad_right;
        logic        dpad_left;
        logic        dpad_down;
        logic        dpad_up;
    } pad_key_t;

    // active-low at the core, coin is the MSB
    typedef struct packed {
        logic coin;
        logic start2;
        logic start1;
        logic shoot2;
        logic shoot;
        logic up;
        logic down;
        logic left;
        logic right;
    } panel_t;

endpackage

//--- src/core_front_top.sv
// configuration and control front end of the arcade core wrapper
// bridge registers, core reset stretcher and control panel mapper

`timescale 1ns/100ps

module core_front_top #(
    parameter logic [31:0] RESET_HOLD_CYCLES = core_cfg_pkg::default_reset_hold
) (
    input  logic                      clk_74a,
    input  logic                      temp_reset,

    // bridge bus, synchronous to clk_74a
    input  logic [31:0]               bridge_addr,
    input  logic                      bridge_rd,
    input  logic                      bridge_wr,
    input  logic [31:0]               bridge_wr_data,
    output logic [31:0]               bridge_rd_data,

    // from the host command handler
    input  logic [31:0]               bridge_cmd_rd_data,
    input  logic                      host_reset_n,

    // pads 1 and 2
    input  core_cfg_pkg::pad_key_t    cont1_key,
    input  core_cfg_pkg::pad_key_t    cont2_key,

    // towards the emulated core
    output logic                      core_reset,
    output core_cfg_pkg::dip_word_u   dip,
    output logic [7:0]                core_mode,
    output logic [3:0]                scanline_level,
    output core_cfg_pkg::panel_t      control_panel
);

    import core_cfg_pkg::*;

    bridge_req_t bridge_req;
    logic        core_reset_req;

    // one bridge access per cycle
    assign bridge_req = '{
        rd:      bridge_rd,
        wr:      bridge_wr,
        addr:    bridge_addr,
        wr_data: bridge_wr_data
    };

    //////////////////////////////////////////////////
    // bridge registers
    //////////////////////////////////////////////////

    bridge_config_regs u_regs (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .bridge         (bridge_req),
        .cmd_rd_data    (bridge_cmd_rd_data),
        .core_reset     (core_reset),
        .rd_data        (bridge_rd_data),
        .dip            (dip),
        .core_mode      (core_mode),
        .scanline_level (scanline_level),
        .core_reset_req (core_reset_req)
    );

    //////////////////////////////////////////////////
    // core reset
    //////////////////////////////////////////////////

    core_reset_timer #(
        .RESET_HOLD_CYCLES (RESET_HOLD_CYCLES)
    ) u_reset_timer (
        .clk_74a        (clk_74a),
        .temp_reset     (temp_reset),
        .core_reset_req (core_reset_req),
        .host_reset_n   (host_reset_n),
        .core_reset     (core_reset)
    );

    //////////////////////////////////////////////////
    // controls
    //////////////////////////////////////////////////

    control_panel_mapper u_panel (
        .clk_74a       (clk_74a),
        .temp_reset    (temp_reset),
        .cont1_key     (cont1_key),
        .cont2_key     (cont2_key),
        .control_panel (control_panel)
    );

endmodule

//--- src/core_reset_timer.sv
// core reset stretcher
// down counter loaded on system reset or a bridge request
// host reset from the command handler is merged in

`timescale 1ns/100ps

module core_reset_timer #(
    parameter logic [31:0] RESET_HOLD_CYCLES = core_cfg_pkg::default_reset_hold
) (
    input  logic clk_74a,
    input  logic temp_reset,
    input  logic core_reset_req,
    input  logic host_reset_n,
    output logic core_reset
);

    logic [31:0] hold_cnt;
    logic        hold_active;

    // loaded value plus the final zero cycle gives HOLD+1 cycles high
    always_ff @(posedge clk_74a) begin
        if (temp_reset || core_reset_req) begin
            hold_cnt    <= RESET_HOLD_CYCLES;
            hold_active <= 1'b1;
        end else if (hold_cnt == 32'd0) begin
            hold_active <= 1'b0;
        end else begin
            hold_cnt    <= hold_cnt - 32'd1;
            hold_active <= 1'b1;
        end
    end

    // host reset acts at once, no stretch
    assign core_reset = hold_active | ~host_reset_n;

    //////////////////////////////////////////////////
    // checks
    //////////////////////////////////////////////////

    // counter only ever counts down from the load value
    cnt_in_range: assert property (
        @(posedge clk_74a) disable iff (temp_reset)
        hold_cnt <= RESET_HOLD_CYCLES
    ) else $error("reset hold counter above RESET_HOLD_CYCLES");

endmodule

//--- test/tb_clk_gen.sv
// free-running testbench clock
// starts low, first rising edge after half a period

`timescale 1ns/100ps

module tb_clk_gen #(
    parameter int PERIOD_NS = 40
) (
    output logic clk
);

    initial begin
        clk = 1'b0;
    end

    always begin
        #(PERIOD_NS / 2) clk = ~clk;
    end

endmodule

//--- test/tb_core_checks.sv
// reference models for the bridge registers, reset stretch and control panel
// concurrent checks against the DUT outputs and the error counter

`timescale 1ns/100ps

module tb_core_checks #(
    parameter logic [31:0] RESET_HOLD_CYCLES = 32'd20
) (
    input  logic        clk_74a,
    input  logic        temp_reset,
    input  logic [31:0] bridge_addr,
    input  logic        bridge_rd,
    input  logic        bridge_wr,
    input  logic [31:0] bridge_wr_data,
    input  logic [31:0] bridge_cmd_rd_data,
    input  logic        host_reset_n,
    input  logic [31:0] cont1_key,
    input  logic [31:0] cont2_key,
    input  logic [31:0] bridge_rd_data,
    input  logic        core_reset,
    input  logic [31:0] dip,
    input  logic [7:0]  core_mode,
    input  logic [3:0]  scanline_level,
    input  logic [8:0]  control_panel,
    output int          value_errs
);

    import core_cfg_pkg::*;

    logic [31:0] model_dip;
    logic [31:0] model_mode;
    logic [31:0] model_scnl;
    logic [31:0] exp_buf;
    logic [8:0]  model_panel;
    logic        req_pend;
    logic        buf_valid;
    logic        model_core_reset;
    int          hold_left;

    initial begin
        value_errs = 0;
        buf_valid  = 1'b0;
    end

    function automatic logic is_mapped(input logic [31:0] addr);
        return (addr == addr_reset) || (addr == addr_dip) ||
               (addr == addr_mode) || (addr == addr_scanlines);
    endfunction

    // key word bit positions: dpad 0-3, b 5, y 7, select 14, start 15
    function automatic logic [8:0] expected_panel(input logic [31:0] k1, input logic [31:0] k2);
        logic [8:0] p;
        p[8] = k1[14] | k2[14];
        p[7] = k2[15];
        p[6] = k1[15];
        p[5] = k1[7] | k2[7];
        p[4] = k1[5] | k2[5];
        p[3] = k1[0] | k2[0];
        p[2] = k1[1] | k2[1];
        p[1] = k1[2] | k2[2];
        p[0] = k1[3] | k2[3];
        return ~p;
    endfunction

    function automatic logic [31:0] read_value(input logic [31:0] addr);
        case (addr)
            addr_reset: return {31'd0, model_core_reset};
            addr_dip:   return model_dip;
            addr_mode:  return model_mode;
            default:    return model_scnl;
        endcase
    endfunction

    function void log_mismatch(input string name, input logic [63:0] expected,
                               input logic [63:0] actual);
        value_errs++;
        $display("ERROR %s: expected %h, actual %h", name, expected, actual);
    endfunction

    ////////////////////////////////////////////////////
    // reference model
    ////////////////////////////////////////////////////

    // hold_left counts the cycles core_reset still has to stay high
    assign model_core_reset = (hold_left != 0) || !host_reset_n;

    always @(posedge clk_74a) begin
        if (temp_reset) begin
            exp_buf     <= '0;
            model_dip   <= '0;
            model_mode  <= '0;
            model_scnl  <= '0;
            req_pend    <= 1'b0;
            hold_left   <= RESET_HOLD_CYCLES + 1;
            model_panel <= '1;
        end else begin
            if (bridge_rd && is_mapped(bridge_addr)) begin
                exp_buf   <= read_value(bridge_addr);
                buf_valid <= 1'b1;
            end
            if (bridge_wr && bridge_addr == addr_dip) begin
                model_dip <= bridge_wr_data;
            end
            if (bridge_wr && bridge_addr == addr_mode) begin
                model_mode <= bridge_wr_data;
            end
            if (bridge_wr && bridge_addr == addr_scanlines) begin
                model_scnl <= bridge_wr_data;
            end
            req_pend <= bridge_wr && (bridge_addr == addr_reset || bridge_addr == addr_dip);
            if (req_pend) begin
                hold_left <= RESET_HOLD_CYCLES + 1;
            end else if (hold_left != 0) begin
                hold_left <= hold_left - 1;
            end
            model_panel <= expected_panel(cont1_key, cont2_key);
        end
    end

    ////////////////////////////////////////////////////
    // checks
    ////////////////////////////////////////////////////

    chk_readback: assert property (@(posedge clk_74a) disable iff (temp_reset)
        (buf_valid && is_mapped(bridge_addr)) |-> bridge_rd_data == exp_buf)
        else log_mismatch("readback", $sampled(exp_buf), $sampled(bridge_rd_data));

    chk_cmd_region: assert property (@(posedge clk_74a) disable iff (temp_reset)
        (bridge_addr[31:24] == cmd_region) |-> bridge_rd_data == bridge_cmd_rd_data)
        else log_mismatch("cmd_region", $sampled(bridge_cmd_rd_data), $sampled(bridge_rd_data));

    chk_unmapped: assert property (@(posedge clk_74a) disable iff (temp_reset)
        (!is_mapped(bridge_addr) && bridge_addr[31:24] != cmd_region) |-> bridge_rd_data == 0)
        else log_mismatch("unmapped", 64'd0, $sampled(bridge_rd_data));

    chk_dip: assert property (@(posedge clk_74a) disable iff (temp_reset) dip == model_dip)
        else log_mismatch("dip", $sampled(model_dip), $sampled(dip));

    chk_mode: assert property (@(posedge clk_74a) disable iff (temp_reset)
        core_mode == model_mode[7:0])
        else log_mismatch("core_mode", $sampled(model_mode[7:0]), $sampled(core_mode));

    chk_scanlines: assert property (@(posedge clk_74a) disable iff (temp_reset)
        scanline_level == model_scnl[3:0])
        else log_mismatch("scanline_level", $sampled(model_scnl[3:0]), $sampled(scanline_level));

    // exact stretch length, reload on a new request
    chk_core_reset: assert property (@(posedge clk_74a) disable iff (temp_reset)
        core_reset == model_core_reset)
        else log_mismatch("core_reset", $sampled(model_core_reset), $sampled(core_reset));

    chk_host_reset: assert property (@(posedge clk_74a) disable iff (temp_reset)
        !host_reset_n |-> core_reset)
        else log_mismatch("host_reset", 64'd1, $sampled(core_reset));

    chk_panel: assert property (@(posedge clk_74a) disable iff (temp_reset)
        control_panel == model_panel)
        else log_mismatch("control_panel", $sampled(model_panel), $sampled(control_panel));

    // fields: core_reset, dip, mode, scanlines, panel
    chk_after_reset: assert property (@(posedge clk_74a)
        $fell(temp_reset) |-> (core_reset && dip == 0 && core_mode == 0 &&
                               scanline_level == 0 && control_panel == 9'h1ff))
        else log_mismatch("after_reset", {1'b1, 32'd0, 8'd0, 4'd0, 9'h1ff},
                          $sampled({core_reset, dip, core_mode, scanline_level, control_panel}));

endmodule

//--- test/tb_core_front.sv
// testbench top for the configuration front end
// clock and reset, bridge and pad stimulus, closing error report

`timescale 1ns/100ps

module tb_core_front;

    import core_cfg_pkg::*;

    localparam logic [31:0] HOLD = 32'd20;

    logic        clk_74a;
    logic        temp_reset;
    logic [31:0] bridge_addr;
    logic        bridge_rd;
    logic        bridge_wr;
    logic [31:0] bridge_wr_data;
    logic [31:0] bridge_cmd_rd_data;
    logic        host_reset_n;
    pad_key_t    cont1_key;
    pad_key_t    cont2_key;
    logic [31:0] bridge_rd_data;
    logic        core_reset;
    dip_word_u   dip;
    logic [7:0]  core_mode;
    logic [3:0]  scanline_level;
    panel_t      control_panel;
    int          value_errs;
    int          timeouts;
    integer      seed;

    tb_clk_gen #(.PERIOD_NS(40)) u_clk (.clk(clk_74a));

    core_front_top #(.RESET_HOLD_CYCLES(HOLD)) UUT (
        .clk_74a            (clk_74a),
        .temp_reset         (temp_reset),
        .bridge_addr        (bridge_addr),
        .bridge_rd          (bridge_rd),
        .bridge_wr          (bridge_wr),
        .bridge_wr_data     (bridge_wr_data),
        .bridge_rd_data     (bridge_rd_data),
        .bridge_cmd_rd_data (bridge_cmd_rd_data),
        .host_reset_n       (host_reset_n),
        .cont1_key          (cont1_key),
        .cont2_key          (cont2_key),
        .core_reset         (core_reset),
        .dip                (dip),
        .core_mode          (core_mode),
        .scanline_level     (scanline_level),
        .control_panel      (control_panel)
    );

    tb_core_checks #(.RESET_HOLD_CYCLES(HOLD)) u_checks (
        .clk_74a            (clk_74a),
        .temp_reset         (temp_reset),
        .bridge_addr        (bridge_addr),
        .bridge_rd          (bridge_rd),
        .bridge_wr          (bridge_wr),
        .bridge_wr_data     (bridge_wr_data),
        .bridge_cmd_rd_data (bridge_cmd_rd_data),
        .host_reset_n       (host_reset_n),
        .cont1_key          (cont1_key),
        .cont2_key          (cont2_key),
        .bridge_rd_data     (bridge_rd_data),
        .core_reset         (core_reset),
        .dip                (dip),
        .core_mode          (core_mode),
        .scanline_level     (scanline_level),
        .control_panel      (control_panel),
        .value_errs         (value_errs)
    );

    ////////////////////////////////////////////////////
    // bus and reset tasks
    ////////////////////////////////////////////////////

    task automatic apply_reset();
        temp_reset = 1'b1;
        repeat (5) @(negedge clk_74a);
        temp_reset = 1'b0;
    endtask

    // one write strobe, then an idle cycle
    task automatic bus_write(input logic [31:0] addr, input logic [31:0] data);
        @(negedge clk_74a);
        bridge_addr    = addr;
        bridge_wr_data = data;
        bridge_wr      = 1'b1;
        @(negedge clk_74a);
        bridge_wr = 1'b0;
        @(negedge clk_74a);
    endtask

    // address held one cycle past the strobe for the readback check
    task automatic bus_read(input logic [31:0] addr);
        @(negedge clk_74a);
        bridge_addr = addr;
        bridge_rd   = 1'b1;
        @(negedge clk_74a);
        bridge_rd = 1'b0;
        @(negedge clk_74a);
    endtask

    task automatic wait_core_reset(input logic level, input int limit, input string what);
        int n;
        n = 0;
        while (core_reset !== level && n < limit) begin
            @(negedge clk_74a);
            n++;
        end
        if (core_reset !== level) begin
            timeouts++;
            $display("timeout: core_reset did not %s within %0d cycles", what, limit);
        end
    endtask

    ////////////////////////////////////////////////////
    // stimulus
    ////////////////////////////////////////////////////

    initial begin
        logic [31:0] rnd;
        seed               = 32'he7245a01;
        timeouts           = 0;
        temp_reset         = 1'b1;
        bridge_addr        = '0;
        bridge_rd          = 1'b0;
        bridge_wr          = 1'b0;
        bridge_wr_data     = '0;
        bridge_cmd_rd_data = '0;
        host_reset_n       = 1'b1;
        cont1_key          = '0;
        cont2_key          = '0;

        apply_reset();
        wait_core_reset(1'b0, HOLD + 8, "fall after temp_reset");

        // mode and scanline writes leave core_reset alone
        for (int i = 0; i < 4; i++) begin
            bus_write(addr_mode, $random(seed));
            bus_write(addr_scanlines, $random(seed));
            bus_read(addr_mode);
            bus_read(addr_scanlines);
        end

        // dip write starts a stretch
        bus_write(addr_dip, $random(seed));
        wait_core_reset(1'b1, 2, "rise after dip write");
        bus_read(addr_dip);
        bus_read(addr_reset);
        wait_core_reset(1'b0, HOLD + 4, "fall after dip write");
        bus_read(addr_reset);

        // reset write, then a reload halfway through the hold
        bus_write(addr_reset, $random(seed));
        wait_core_reset(1'b1, 2, "rise after reset write");
        repeat (8) @(negedge clk_74a);
        bus_write(addr_reset, $random(seed));
        wait_core_reset(1'b0, HOLD + 8, "fall after reload");

        // host reset from the command handler
        @(negedge clk_74a);
        host_reset_n = 1'b0;
        bus_read(addr_reset);
        @(negedge clk_74a);
        host_reset_n = 1'b1;
        bus_read(addr_reset);

        // command region passthrough and unmapped space
        for (int i = 0; i < 4; i++) begin
            rnd                = $random(seed);
            bridge_cmd_rd_data = $random(seed);
            bus_read({cmd_region, rnd[23:0]});
            bus_read({8'hF4, rnd[23:0]});
            bus_read(rnd & 32'h7FFF_FFFF);
        end

        // random pad key words, new pair every cycle
        repeat (50) begin
            @(negedge clk_74a);
            cont1_key = pad_key_t'($random(seed));
            cont2_key = pad_key_t'($random(seed));
        end

        // second system reset with nonzero configuration
        bus_write(addr_mode, 32'hFFFF_FFFF);
        bus_write(addr_scanlines, 32'hFFFF_FFFF);
        bus_write(addr_dip, $random(seed));
        @(negedge clk_74a);
        apply_reset();
        wait_core_reset(1'b0, HOLD + 8, "fall after second temp_reset");

        repeat (3) @(negedge clk_74a);
        $display("error counts: %0d check, %0d timeout", value_errs, timeouts);
        if (value_errs == 0 && timeouts == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
